// ==== sram_adapter_pkg.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Bus to SRAM adapter package
// Bus widths, opcodes, channel and queue entry structs, blanking words
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`default_nettype none

package sram_adapter_pkg;

  // Bus geometry
  localparam int BusDw   = 64;
  localparam int BusDbw  = BusDw / 8;
  localparam int BusAw   = 32;
  localparam int SourceW = 8;
  localparam int SizeW   = 3;
  // Offset of a bus word in the SRAM word, room for four bus words
  localparam int MaxWoffW = 2;

  // Response data on write acks and errors
  localparam logic [BusDw-1:0] DataWhenError      = 64'h0000_0000_0000_0000;
  localparam logic [BusDw-1:0] DataWhenInstrError = 64'hFFFF_FFFF_FFFF_FFFF;

  // Request opcodes
  typedef enum logic [2:0] {
    PutFullData    = 3'h0,
    PutPartialData = 3'h1,
    Get            = 3'h4
  } a_opcode_e;

  // Response opcodes
  typedef enum logic [2:0] {
    AccessAck     = 3'h0,
    AccessAckData = 3'h1
  } d_opcode_e;

  // A channel payload
  typedef struct packed {
    a_opcode_e           opcode;
    logic [SizeW-1:0]    size;
    logic [SourceW-1:0]  source;
    logic [BusAw-1:0]    address;
    logic [BusDbw-1:0]   mask;
    logic [BusDw-1:0]    data;
    // Set on instruction fetch
    logic                instr;
  } bus_a_t;

  // D channel payload
  typedef struct packed {
    d_opcode_e           opcode;
    logic [SizeW-1:0]    size;
    logic [SourceW-1:0]  source;
    logic [BusDw-1:0]    data;
    logic                error;
  } bus_d_t;

  typedef enum logic {
    OpWrite = 1'b0,
    OpRead  = 1'b1
  } req_op_e;

  // One entry per accepted request, popped on the D transfer
  typedef struct packed {
    req_op_e             op;
    logic                error;
    logic                instr;
    logic [SizeW-1:0]    size;
    logic [SourceW-1:0]  source;
  } req_desc_t;

  // Byte mask and word select of a read in flight
  typedef struct packed {
    logic [BusDbw-1:0]   mask;
    logic [MaxWoffW-1:0] woffset;
  } rd_sel_t;

  // Returned read word
  typedef struct packed {
    logic [BusDw-1:0]    data;
    logic                error;
  } rd_rsp_t;

endpackage

`default_nettype wire

// ==== fifo_sync.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Synchronous FIFO for any payload type, optional same-cycle pass-through
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps
`default_nettype none

module fifo_sync #(
  parameter type T     = logic [7:0],
  parameter int  Depth = 2,
  parameter bit  Pass  = 1'b0
) (
  input  wire logic clk_i,
  input  wire logic rst_ni,
  // Write side
  input  wire logic wvalid_i,
  output logic      wready_o,
  input  wire T     wdata_i,
  // Read side
  output logic      rvalid_o,
  input  wire logic rready_i,
  output T          rdata_o
);

  localparam int PtrW = (Depth > 1) ? $clog2(Depth) : 1;
  localparam int CntW = $clog2(Depth + 1);

  T                mem_q [Depth];
  logic [PtrW-1:0] wptr_q;
  logic [PtrW-1:0] rptr_q;
  logic [CntW-1:0] cnt_q;
  logic            empty;
  logic            full;
  logic            bypass;
  logic            push;
  logic            pop;

  assign empty  = (cnt_q == '0);
  assign full   = (cnt_q == CntW'(Depth));
  // Empty pass-through FIFO hands the write side straight to the read side
  assign bypass = Pass & empty;

  assign wready_o = ~full;
  assign rvalid_o = ~empty | (bypass & wvalid_i);
  assign rdata_o  = bypass ? wdata_i : mem_q[rptr_q];

  // Forwarded entry taken in the same cycle is never stored
  assign push = wvalid_i & ~full & ~(bypass & rready_i);
  assign pop  = rready_i & ~empty;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wptr_q <= '0;
      rptr_q <= '0;
      cnt_q  <= '0;
    end else begin
      if (push) begin
        wptr_q <= (wptr_q == PtrW'(Depth - 1)) ? '0 : wptr_q + 1'b1;
      end
      if (pop) begin
        rptr_q <= (rptr_q == PtrW'(Depth - 1)) ? '0 : rptr_q + 1'b1;
      end
      cnt_q <= cnt_q + CntW'(push) - CntW'(pop);
    end
  end

  // Storage
  always_ff @(posedge clk_i) begin
    if (push) begin
      mem_q[wptr_q] <= wdata_i;
    end
  end

endmodule

`default_nettype wire

// ==== sram_req_gen.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Request side of the adapter, checks A requests, drives the SRAM request
// and builds the descriptor and read-select queue entries
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps
`default_nettype none

module sram_req_gen
  import sram_adapter_pkg::*;
#(
  parameter int SramAw     = 10,
  parameter int SramDw     = 128,
  parameter bit ByteAccess = 1'b1
) (
  input  wire logic        clk_i,
  input  wire logic        rst_ni,
  // A channel
  input  wire logic        a_valid_i,
  output logic             a_ready_o,
  input  wire bus_a_t      a_i,
  input  wire logic        en_ifetch_i,
  // SRAM request
  output logic             req_o,
  input  wire logic        gnt_i,
  output logic             we_o,
  output logic [SramAw-1:0] addr_o,
  output logic [SramDw-1:0] wdata_o,
  output logic [SramDw-1:0] wmask_o,
  // Queue pushes
  output logic             desc_valid_o,
  input  wire logic        desc_ready_i,
  output req_desc_t        desc_o,
  output logic             sel_valid_o,
  input  wire logic        sel_ready_i,
  output rd_sel_t          sel_o
);

  localparam int WidthMult = SramDw / BusDw;
  localparam int ByteBits  = $clog2(BusDbw);
  localparam int WordBits  = $clog2(SramDw / 8);

  logic                            is_get;
  logic                            is_write;
  logic                            op_error;
  logic                            instr_error;
  logic                            attr_error;
  logic                            error;
  logic                            a_ack;
  logic                            sram_ack;
  logic [MaxWoffW-1:0]             woffset;
  logic [SramAw-1:0]               addr_d;
  logic [SramAw-1:0]               addr_q;
  logic [BusDw-1:0]                mask_bits;
  logic [WidthMult-1:0][BusDw-1:0] wmask_words;
  logic [WidthMult-1:0][BusDw-1:0] wdata_words;

  assign is_get   = (a_i.opcode == Get);
  assign is_write = (a_i.opcode == PutFullData) || (a_i.opcode == PutPartialData);

  // Refused requests, answered with an error and kept off the SRAM
  assign op_error    = ~is_get & ~is_write;
  assign instr_error = a_i.instr & ~en_ifetch_i;
  // Without byte access only full-mask writes pass
  assign attr_error  = ~ByteAccess & is_write &
                       ((a_i.opcode == PutPartialData) || (a_i.mask != '1));
  assign error       = op_error | instr_error | attr_error;

  // Bus word position inside the SRAM word
  if (WidthMult > 1) begin : gen_woffset
    assign woffset = MaxWoffW'(a_i.address[WordBits-1:ByteBits]);
  end else begin : gen_no_woffset
    assign woffset = '0;
  end
  assign addr_d = a_i.address[WordBits +: SramAw];

  // Handshakes
  // Error requests complete without a grant
  assign a_ready_o = (gnt_i | error) & desc_ready_i & sel_ready_i;
  assign req_o     = a_valid_i & desc_ready_i & ~error;
  assign we_o      = a_valid_i & is_write;
  assign a_ack     = a_valid_i & a_ready_o;
  assign sram_ack  = req_o & gnt_i;

  // Idle SRAM address keeps the last granted one
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      addr_q <= '0;
    end else if (sram_ack) begin
      addr_q <= addr_d;
    end
  end
  assign addr_o = req_o ? addr_d : addr_q;

  // Byte mask spread to bits
  always_comb begin
    for (int i = 0; i < BusDbw; i++) begin
      mask_bits[8*i +: 8] = {8{a_i.mask[i]}};
    end
  end

  // Only the selected slot carries mask and data
  always_comb begin
    wmask_words = '0;
    wdata_words = '0;
    for (int w = 0; w < WidthMult; w++) begin
      if (woffset == MaxWoffW'(w)) begin
        wmask_words[w] = mask_bits;
        wdata_words[w] = we_o ? (a_i.data & mask_bits) : '0;
      end
    end
  end
  assign wmask_o = wmask_words;
  assign wdata_o = wdata_words;

  // Descriptor on every acceptance, error requests other than get count as writes
  assign desc_valid_o = a_ack;
  always_comb begin
    desc_o        = '0;
    desc_o.op     = OpWrite;
    if (is_get) begin
      desc_o.op = OpRead;
    end
    desc_o.error  = error;
    desc_o.instr  = a_i.instr;
    desc_o.size   = a_i.size;
    desc_o.source = a_i.source;
  end

  // Read select only for reads that reached the SRAM
  assign sel_valid_o   = a_ack & ~error & ~we_o;
  assign sel_o.mask    = a_i.mask;
  assign sel_o.woffset = woffset;

endmodule

`default_nettype wire

// ==== sram_rsp_gen.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Response side of the adapter, picks returned read words and builds
// in-order D responses with error blanking
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps
`default_nettype none

module sram_rsp_gen
  import sram_adapter_pkg::*;
#(
  parameter int SramDw = 128
) (
  // SRAM read return
  input  wire logic              rvalid_i,
  input  wire logic [SramDw-1:0] rdata_i,
  input  wire logic              rerror_i,
  // Queue heads
  input  wire logic              desc_valid_i,
  output logic                   desc_ready_o,
  input  wire req_desc_t         desc_i,
  output logic                   sel_ready_o,
  input  wire rd_sel_t           sel_i,
  // Read-data queue push and pop
  output logic                   rsp_valid_o,
  output rd_rsp_t                rsp_o,
  input  wire logic              rsp_valid_i,
  output logic                   rsp_ready_o,
  input  wire rd_rsp_t           rsp_i,
  // D channel
  output logic                   d_valid_o,
  input  wire logic              d_ready_i,
  output bus_d_t                 d_o
);

  localparam int WidthMult = SramDw / BusDw;

  logic [WidthMult-1:0][BusDw-1:0] rdata_words;
  logic [BusDw-1:0]                rword;
  logic [BusDw-1:0]                rmask;
  logic [BusDw-1:0]                blank_data;
  logic                            rd_ok;
  logic                            d_ack;
  logic                            d_error;

  assign rdata_words = rdata_i;

  // Word select and byte masking of the returned SRAM word
  always_comb begin
    rword = '0;
    for (int w = 0; w < WidthMult; w++) begin
      if (sel_i.woffset == MaxWoffW'(w)) begin
        rword = rdata_words[w];
      end
    end
    for (int i = 0; i < BusDbw; i++) begin
      rmask[8*i +: 8] = {8{sel_i.mask[i]}};
    end
  end

  // Read data always lands in the queue, the select entry goes with it
  assign rsp_valid_o = rvalid_i & desc_valid_i;
  assign rsp_o.data  = rword & rmask;
  // Uncorrectable error from the SRAM
  assign rsp_o.error = rerror_i;
  assign sel_ready_o = rsp_valid_o;

  // Error-free reads wait for their data
  assign rd_ok     = (desc_i.op == OpRead) & ~desc_i.error;
  assign d_valid_o = desc_valid_i & (~rd_ok | rsp_valid_i);
  assign d_ack     = d_valid_o & d_ready_i;

  assign desc_ready_o = d_ack;
  assign rsp_ready_o  = d_ack & rd_ok;

  assign d_error    = desc_i.error | (rd_ok & rsp_i.error);
  // Refused fetches get their own pattern
  assign blank_data = (desc_i.error & desc_i.instr) ? DataWhenInstrError : DataWhenError;

  always_comb begin
    d_o        = '0;
    d_o.opcode = AccessAck;
    if (desc_i.op == OpRead) begin
      d_o.opcode = AccessAckData;
    end
    d_o.size   = desc_i.size;
    d_o.source = desc_i.source;
    d_o.data   = (rd_ok & ~rsp_i.error) ? rsp_i.data : blank_data;
    d_o.error  = d_error;
  end

endmodule

`default_nettype wire

// ==== sram_adapter.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Bus to wide SRAM adapter, request side, three response queues and
// response side
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps
`default_nettype none

module sram_adapter
  import sram_adapter_pkg::*;
#(
  parameter int SramAw      = 10,
  // Multiple of BusDw, at most 256
  parameter int SramDw      = 128,
  parameter int Outstanding = 2,
  parameter bit ByteAccess  = 1'b1
) (
  input  wire logic              clk_i,
  input  wire logic              rst_ni,
  // Bus side
  input  wire logic              a_valid_i,
  output logic                   a_ready_o,
  input  wire bus_a_t            a_i,
  output logic                   d_valid_o,
  input  wire logic              d_ready_i,
  output bus_d_t                 d_o,
  input  wire logic              en_ifetch_i,
  // SRAM side
  output logic                   req_o,
  input  wire logic              gnt_i,
  output logic                   we_o,
  output logic [SramAw-1:0]      addr_o,
  output logic [SramDw-1:0]      wdata_o,
  output logic [SramDw-1:0]      wmask_o,
  input  wire logic [SramDw-1:0] rdata_i,
  input  wire logic              rvalid_i,
  input  wire logic              rerror_i
);

  // Descriptor queue
  logic      desc_wvalid;
  logic      desc_wready;
  req_desc_t desc_wdata;
  logic      desc_rvalid;
  logic      desc_rready;
  req_desc_t desc_rdata;
  // Read-select queue
  logic      sel_wvalid;
  logic      sel_wready;
  rd_sel_t   sel_wdata;
  logic      sel_rready;
  rd_sel_t   sel_rdata;
  // Read-data queue
  logic      rsp_wvalid;
  rd_rsp_t   rsp_wdata;
  logic      rsp_rvalid;
  logic      rsp_rready;
  rd_rsp_t   rsp_rdata;

  sram_req_gen #(
    .SramAw     (SramAw),
    .SramDw     (SramDw),
    .ByteAccess (ByteAccess)
  ) u_req_gen (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .a_valid_i    (a_valid_i),
    .a_ready_o    (a_ready_o),
    .a_i          (a_i),
    .en_ifetch_i  (en_ifetch_i),
    .req_o        (req_o),
    .gnt_i        (gnt_i),
    .we_o         (we_o),
    .addr_o       (addr_o),
    .wdata_o      (wdata_o),
    .wmask_o      (wmask_o),
    .desc_valid_o (desc_wvalid),
    .desc_ready_i (desc_wready),
    .desc_o       (desc_wdata),
    .sel_valid_o  (sel_wvalid),
    .sel_ready_i  (sel_wready),
    .sel_o        (sel_wdata)
  );

  // One entry per accepted request, responses leave in this order
  fifo_sync #(
    .T     (req_desc_t),
    .Depth (Outstanding),
    .Pass  (1'b0)
  ) u_desc_fifo (
    .clk_i    (clk_i),
    .rst_ni   (rst_ni),
    .wvalid_i (desc_wvalid),
    .wready_o (desc_wready),
    .wdata_i  (desc_wdata),
    .rvalid_o (desc_rvalid),
    .rready_i (desc_rready),
    .rdata_o  (desc_rdata)
  );

  // Mask and offset of granted reads until their data returns
  fifo_sync #(
    .T     (rd_sel_t),
    .Depth (Outstanding),
    .Pass  (1'b0)
  ) u_sel_fifo (
    .clk_i    (clk_i),
    .rst_ni   (rst_ni),
    .wvalid_i (sel_wvalid),
    .wready_o (sel_wready),
    .wdata_i  (sel_wdata),
    .rvalid_o (),
    .rready_i (sel_rready),
    .rdata_o  (sel_rdata)
  );

  // Holds read data while the D channel stalls, SRAM has no back-pressure
  fifo_sync #(
    .T     (rd_rsp_t),
    .Depth (Outstanding),
    .Pass  (1'b1)
  ) u_rsp_fifo (
    .clk_i    (clk_i),
    .rst_ni   (rst_ni),
    .wvalid_i (rsp_wvalid),
    .wready_o (),
    .wdata_i  (rsp_wdata),
    .rvalid_o (rsp_rvalid),
    .rready_i (rsp_rready),
    .rdata_o  (rsp_rdata)
  );

  sram_rsp_gen #(
    .SramDw (SramDw)
  ) u_rsp_gen (
    .rvalid_i     (rvalid_i),
    .rdata_i      (rdata_i),
    .rerror_i     (rerror_i),
    .desc_valid_i (desc_rvalid),
    .desc_ready_o (desc_rready),
    .desc_i       (desc_rdata),
    .sel_ready_o  (sel_rready),
    .sel_i        (sel_rdata),
    .rsp_valid_o  (rsp_wvalid),
    .rsp_o        (rsp_wdata),
    .rsp_valid_i  (rsp_rvalid),
    .rsp_ready_o  (rsp_rready),
    .rsp_i        (rsp_rdata),
    .d_valid_o    (d_valid_o),
    .d_ready_i    (d_ready_i),
    .d_o          (d_o)
  );

endmodule

`default_nettype wire

// ==== tb_sram_model.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Behavioral wide SRAM for the testbench, random grant, one-cycle read
// latency and read error injection
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps
`default_nettype none

module tb_sram_model #(
  parameter int SramAw = 10,
  parameter int SramDw = 128
) (
  input  wire logic              clk_i,
  input  wire logic              rst_ni,
  input  wire logic              req_i,
  output logic                   gnt_o,
  input  wire logic              we_i,
  input  wire logic [SramAw-1:0] addr_i,
  input  wire logic [SramDw-1:0] wdata_i,
  input  wire logic [SramDw-1:0] wmask_i,
  output logic [SramDw-1:0]      rdata_o,
  output logic                   rvalid_o,
  output logic                   rerror_o,
  // Marks the next granted read as uncorrectable
  input  wire logic              inject_err_i
);

  logic [SramDw-1:0] mem [2**SramAw];
  logic              gnt_q;
  logic              rd_take;
  logic              wr_take;
  integer            seed;

  initial seed = 32'h4bfb;

  assign gnt_o   = gnt_q;
  assign rd_take = req_i & gnt_q & ~we_i;
  assign wr_take = req_i & gnt_q & we_i;

  always @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      gnt_q    <= 1'b0;
      rvalid_o <= 1'b0;
      rerror_o <= 1'b0;
      rdata_o  <= '0;
    end else begin
      // Grant in about three cycles of four
      gnt_q    <= (($random(seed) & 32'd3) != 32'd0);
      rvalid_o <= rd_take;
      rerror_o <= rd_take & inject_err_i;
      if (rd_take) begin
        rdata_o <= mem[addr_i];
      end
      // Bit-masked write
      if (wr_take) begin
        mem[addr_i] <= (mem[addr_i] & ~wmask_i) | (wdata_i & wmask_i);
      end
    end
  end

endmodule

`default_nettype wire

// ==== tb_sram_adapter.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Testbench for the bus to SRAM adapter, directed tests against a
// per bus word reference memory
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps
`default_nettype none

module tb_sram_adapter
  import sram_adapter_pkg::*;
;

  localparam int SramAw      = 10;
  localparam int SramDw      = 128;
  localparam int Outstanding = 2;
  // Roughly 500 cycles of tests at a slow grant rate, four times that as limit
  localparam int TestCycles    = 500;
  localparam int TimeoutCycles = 4 * TestCycles;
  localparam logic [SizeW-1:0] Size8 = 3'd3;

  logic              clk_i = 1'b0;
  logic              rst_ni;
  logic              a_valid_i;
  logic              a_ready_o;
  bus_a_t            a_req;
  logic              d_valid_o;
  logic              d_ready_i;
  bus_d_t            d_o;
  logic              en_ifetch_i;
  logic              req_o;
  logic              gnt_i;
  logic              we_o;
  logic [SramAw-1:0] addr_o;
  logic [SramDw-1:0] wdata_o;
  logic [SramDw-1:0] wmask_o;
  logic [SramDw-1:0] rdata_i;
  logic              rvalid_i;
  logic              rerror_i;
  logic              inject_err;

  // Expected contents, one entry per bus word of the address range in use
  logic [BusDw-1:0]  ref_mem [2048];
  logic [BusAw-1:0]  addrs [8];
  integer            seed;
  int                cycles = 0;

  always #2 clk_i = ~clk_i;

  sram_adapter #(
    .SramAw      (SramAw),
    .SramDw      (SramDw),
    .Outstanding (Outstanding),
    .ByteAccess  (1'b1)
  ) sram_adapter_inst (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .a_valid_i   (a_valid_i),
    .a_ready_o   (a_ready_o),
    .a_i         (a_req),
    .d_valid_o   (d_valid_o),
    .d_ready_i   (d_ready_i),
    .d_o         (d_o),
    .en_ifetch_i (en_ifetch_i),
    .req_o       (req_o),
    .gnt_i       (gnt_i),
    .we_o        (we_o),
    .addr_o      (addr_o),
    .wdata_o     (wdata_o),
    .wmask_o     (wmask_o),
    .rdata_i     (rdata_i),
    .rvalid_i    (rvalid_i),
    .rerror_i    (rerror_i)
  );

  tb_sram_model #(
    .SramAw (SramAw),
    .SramDw (SramDw)
  ) u_sram (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .req_i        (req_o),
    .gnt_o        (gnt_i),
    .we_i         (we_o),
    .addr_i       (addr_o),
    .wdata_i      (wdata_o),
    .wmask_i      (wmask_o),
    .rdata_o      (rdata_i),
    .rvalid_o     (rvalid_i),
    .rerror_o     (rerror_i),
    .inject_err_i (inject_err)
  );

  task automatic stop_on_failure();
    $display("Result: FAILED");
    $fatal(1, "stopped at the first error");
  endtask

  // Hung handshake guard
  always @(posedge clk_i) begin
    cycles <= cycles + 1;
    if (cycles >= TimeoutCycles) begin
      $display("Timeout: the tests did not finish within %0d cycles", TimeoutCycles);
      stop_on_failure();
    end
  end

  task automatic check_d(input string name, input bus_d_t expected, input bus_d_t act);
    if (act !== expected) begin
      $display("CHECK FAILED %s: expected %h, actual %h", name, expected, act);
      stop_on_failure();
    end
  endtask

  task automatic check_bit(input string name, input logic expected, input logic act);
    if (act !== expected) begin
      $display("CHECK FAILED %s: expected %b, actual %b", name, expected, act);
      stop_on_failure();
    end
  endtask

  task automatic check_addr(input string name, input logic [SramAw-1:0] expected,
                            input logic [SramAw-1:0] act);
    if (act !== expected) begin
      $display("CHECK FAILED %s: expected %h, actual %h", name, expected, act);
      stop_on_failure();
    end
  endtask

  task automatic check_word(input string name, input logic [SramDw-1:0] expected,
                            input logic [SramDw-1:0] act);
    if (act !== expected) begin
      $display("CHECK FAILED %s: expected %h, actual %h", name, expected, act);
      stop_on_failure();
    end
  endtask

  function automatic bus_a_t make_req(a_opcode_e op, logic [BusAw-1:0] addr,
                                      logic [BusDbw-1:0] mask, logic [BusDw-1:0] data,
                                      logic [SourceW-1:0] src, logic instr);
    bus_a_t r;
    r.opcode  = op;
    r.size    = Size8;
    r.source  = src;
    r.address = addr;
    r.mask    = mask;
    r.data    = data;
    r.instr   = instr;
    return r;
  endfunction

  function automatic bus_d_t make_rsp(d_opcode_e op, logic [SourceW-1:0] src,
                                      logic [BusDw-1:0] data, logic err);
    bus_d_t r;
    r.opcode = op;
    r.size   = Size8;
    r.source = src;
    r.data   = data;
    r.error  = err;
    return r;
  endfunction

  // Byte mask to bit mask
  function automatic logic [BusDw-1:0] byte_bits(logic [BusDbw-1:0] m);
    logic [BusDw-1:0] b;
    for (int i = 0; i < BusDbw; i++) begin
      b[8*i +: 8] = {8{m[i]}};
    end
    return b;
  endfunction

  // Holds the request until a_ready_o, optionally checking it stays off the SRAM
  task automatic send_req(input string name, input bus_a_t req, input logic no_sram);
    logic              done;
    logic              wr;
    int                slot;
    logic [SramDw-1:0] exp_mask;
    logic [SramDw-1:0] exp_data;
    wr        = (req.opcode == PutFullData) || (req.opcode == PutPartialData);
    // Bus word slot inside the SRAM word
    slot      = int'(req.address[3]);
    exp_mask  = SramDw'(byte_bits(req.mask)) << (BusDw * slot);
    exp_data  = SramDw'(req.data & byte_bits(req.mask)) << (BusDw * slot);
    a_req     = req;
    a_valid_i = 1'b1;
    done      = 1'b0;
    while (!done) begin
      @(negedge clk_i);
      if (no_sram) begin
        check_bit(name, 1'b0, req_o);
      end else if (req_o && gnt_i) begin
        check_addr(name, req.address[4 +: SramAw], addr_o);
        check_bit(name, wr, we_o);
        if (wr) begin
          check_word(name, exp_mask, wmask_o);
          check_word(name, exp_data, wdata_o);
        end
      end
      done = a_ready_o;
      @(posedge clk_i);
      #0.5;
    end
    a_valid_i = 1'b0;
  endtask

  task automatic wait_rsp(input string name, input bus_d_t expected);
    logic got;
    d_ready_i = 1'b1;
    got       = 1'b0;
    while (!got) begin
      @(negedge clk_i);
      got = d_valid_o;
      if (got) begin
        check_d(name, expected, d_o);
      end
      @(posedge clk_i);
      #0.5;
    end
    d_ready_i = 1'b0;
  endtask

  task automatic write_word(input string name, input a_opcode_e op, input logic [BusAw-1:0] addr,
                            input logic [BusDbw-1:0] mask, input logic [BusDw-1:0] data,
                            input logic [SourceW-1:0] src);
    logic [BusDw-1:0] bits;
    bits = byte_bits(mask);
    send_req(name, make_req(op, addr, mask, data, src, 1'b0), 1'b0);
    wait_rsp(name, make_rsp(AccessAck, src, DataWhenError, 1'b0));
    ref_mem[addr[13:3]] = (ref_mem[addr[13:3]] & ~bits) | (data & bits);
  endtask

  // Unmasked bytes of a read come back zero
  task automatic read_word(input string name, input logic [BusAw-1:0] addr,
                           input logic [BusDbw-1:0] mask, input logic [SourceW-1:0] src);
    logic [BusDw-1:0] expected;
    expected = ref_mem[addr[13:3]] & byte_bits(mask);
    send_req(name, make_req(Get, addr, mask, '0, src, 1'b0), 1'b0);
    wait_rsp(name, make_rsp(AccessAckData, src, expected, 1'b0));
  endtask

  task automatic test_full_rw();
    logic [BusDw-1:0] data;
    for (int i = 0; i < 8; i++) begin
      data = {$random(seed), $random(seed)};
      write_word("full_write", PutFullData, addrs[i], 8'hff, data, 8'(i));
    end
    for (int i = 0; i < 8; i++) begin
      read_word("full_read", addrs[i], 8'hff, 8'(8 + i));
    end
  endtask

  task automatic test_partial_write();
    logic [31:0]      rnd;
    logic [BusDw-1:0] data;
    for (int i = 0; i < 6; i++) begin
      rnd  = $random(seed);
      data = {$random(seed), $random(seed)};
      write_word("partial_write", PutPartialData, addrs[rnd[10:8]], rnd[7:0], data,
                 8'(8'h20 + i));
    end
    for (int i = 0; i < 8; i++) begin
      read_word("partial_merge_read", addrs[i], 8'hff, 8'(8'h28 + i));
    end
  endtask

  task automatic test_partial_read();
    logic [31:0] rnd;
    for (int i = 0; i < 4; i++) begin
      rnd = $random(seed);
      read_word("partial_read", addrs[2*i + 1], rnd[7:0], 8'(8'h30 + i));
    end
  endtask

  task automatic test_fetch_and_opcode();
    en_ifetch_i = 1'b0;
    send_req("fetch_off", make_req(Get, addrs[2], 8'hff, '0, 8'h40, 1'b1), 1'b1);
    wait_rsp("fetch_off", make_rsp(AccessAckData, 8'h40, DataWhenInstrError, 1'b1));
    en_ifetch_i = 1'b1;
    send_req("fetch_on", make_req(Get, addrs[2], 8'hff, '0, 8'h41, 1'b1), 1'b0);
    wait_rsp("fetch_on", make_rsp(AccessAckData, 8'h41, ref_mem[addrs[2][13:3]], 1'b0));
    // Unknown opcode must not write
    send_req("bad_opcode", make_req(a_opcode_e'(3'h2), addrs[3], 8'hff,
             64'hdead_beef_0bad_f00d, 8'h42, 1'b0), 1'b1);
    wait_rsp("bad_opcode", make_rsp(AccessAck, 8'h42, DataWhenError, 1'b1));
    read_word("bad_opcode_read", addrs[3], 8'hff, 8'h43);
  endtask

  task automatic test_backpressure();
    bus_d_t expected [3];
    logic   accepted;
    int     got;
    for (int i = 0; i < 3; i++) begin
      expected[i] = make_rsp(AccessAckData, 8'(8'h50 + i), ref_mem[addrs[4 + i][13:3]], 1'b0);
    end
    d_ready_i = 1'b0;
    send_req("bp_read", make_req(Get, addrs[4], 8'hff, '0, 8'h50, 1'b0), 1'b0);
    send_req("bp_read", make_req(Get, addrs[5], 8'hff, '0, 8'h51, 1'b0), 1'b0);
    // Queues full, the third request has to wait
    a_req     = make_req(Get, addrs[6], 8'hff, '0, 8'h52, 1'b0);
    a_valid_i = 1'b1;
    repeat (4) begin
      @(negedge clk_i);
      check_bit("bp_a_ready", 1'b0, a_ready_o);
      check_bit("bp_req", 1'b0, req_o);
      // Oldest response stays on the D channel while stalled
      check_bit("bp_d_valid", 1'b1, d_valid_o);
      check_d("bp_hold", expected[0], d_o);
      @(posedge clk_i);
      #0.5;
    end
    d_ready_i = 1'b1;
    got       = 0;
    while (got < 3) begin
      @(negedge clk_i);
      accepted = a_valid_i & a_ready_o;
      if (d_valid_o) begin
        check_d("bp_order", expected[got], d_o);
        got++;
      end
      @(posedge clk_i);
      #0.5;
      if (accepted) begin
        a_valid_i = 1'b0;
      end
    end
    d_ready_i = 1'b0;
  endtask

  task automatic test_read_error();
    inject_err = 1'b1;
    send_req("err_read", make_req(Get, addrs[7], 8'hff, '0, 8'h60, 1'b0), 1'b0);
    inject_err = 1'b0;
    wait_rsp("err_read", make_rsp(AccessAckData, 8'h60, DataWhenError, 1'b1));
    read_word("after_err_read", addrs[7], 8'hff, 8'h61);
  endtask

  initial begin
    seed        = 32'h4bfb;
    rst_ni      = 1'b0;
    a_valid_i   = 1'b0;
    a_req       = '0;
    d_ready_i   = 1'b0;
    en_ifetch_i = 1'b1;
    inject_err  = 1'b0;
    // Both bus words of four SRAM words
    for (int i = 0; i < 8; i++) begin
      addrs[i] = 32'h0000_0200 + 32'(16 * (i / 2) + 8 * (i % 2));
    end
    repeat (4) @(posedge clk_i);
    #0.5;
    rst_ni = 1'b1;
    check_bit("reset_d_valid", 1'b0, d_valid_o);
    check_bit("reset_req", 1'b0, req_o);
    test_full_rw();
    test_partial_write();
    test_partial_read();
    test_fetch_and_opcode();
    test_backpressure();
    test_read_error();
    $display("Result: PASSED");
    $finish;
  end

endmodule

`default_nettype wire

// ==== verilog.f ====
sram_adapter_pkg.sv
fifo_sync.sv
sram_req_gen.sv
sram_rsp_gen.sv
sram_adapter.sv
tb_sram_model.sv
tb_sram_adapter.sv

// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing
TOP       = tb_sram_adapter
FILELIST  = verilog.f
LOG       = sim.log
PASS_MSG  = Result: PASSED

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
